// ==== build.f ====
logic/conv_ctrl_pkg.sv
logic/cfg_latch.sv
logic/phase_sequencer.sv
logic/ctrl_decoder.sv
logic/conv_ctrl_top.sv
testbench/tb_conv_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the convolution controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_conv_ctrl
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f build.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass line not found in $LOG"
exit 1

// ==== testbench/tb_conv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_ctrl;

    localparam int NUM_RUNS        = 6;
    localparam int MAX_TILES       = ((20 - 2 + 1) * (20 - 2 + 1) + 7) / 8;  // N=20, K=2
    localparam int WATCHDOG_CYCLES = NUM_RUNS * MAX_TILES * 200;

    logic                            clk;
    logic                            rst_n;
    logic                            start;
    conv_ctrl_pkg::conv_cfg_t        cfg;
    logic                            rx_valid;
    logic                            tx_ready;
    logic                            tile_done;
    logic                            done;
    logic                            rx_ready;
    logic                            tx_valid;
    conv_ctrl_pkg::agu_ctrl_t        agu;
    conv_ctrl_pkg::mem_ctrl_t        mem;
    conv_ctrl_pkg::sa_ctrl_t         sa;
    conv_ctrl_pkg::phase_t           phase;
    logic [conv_ctrl_pkg::CNT_W-1:0] cycle_count;

    // ======================================================================
    // Model state and bookkeeping
    // ======================================================================
    logic [31:0]           lcg_state;
    int                    error_count;
    int                    runs_done;
    int                    tiles_total;
    int                    exp_weights;     // K*K
    int                    exp_outputs;     // (N-K+1)^2
    int                    exp_tiles;       // Outputs / 8 rounded up
    int                    rx_beats;        // Beats in current rx_ready span
    int                    tx_beats;        // Beats in current drain
    int                    drains;
    int                    tiles_started;
    int                    active_cycles;   // Cycles out of IDLE this run
    int                    compute_cycles;
    int                    done_delay;
    bit                    run_active;
    bit                    done_seen;
    bit                    first_span;      // Weights plus first tile
    bit                    tile_done_seen;
    conv_ctrl_pkg::phase_t prev_phase;
    conv_ctrl_pkg::phase_t prev2_phase;
    logic                  prev_rx_valid;
    logic                  prev_rx_ready;
    logic                  prev_tx_valid;
    logic                  prev_done;

    conv_ctrl_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .rx_valid    (rx_valid),
        .tx_ready    (tx_ready),
        .tile_done   (tile_done),
        .done        (done),
        .rx_ready    (rx_ready),
        .tx_valid    (tx_valid),
        .agu         (agu),
        .mem         (mem),
        .sa          (sa),
        .phase       (phase),
        .cycle_count (cycle_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // Bound from worst tile count per run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: runs did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);   // Upper bits, better period
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + (lcg_next() % (hi - lo + 1));
    endfunction

    // Address generator mode expected for a phase
    function automatic conv_ctrl_pkg::agu_mode_t mode_of(input conv_ctrl_pkg::phase_t p);
        case (p)
            conv_ctrl_pkg::LOAD_WEIGHTS: return conv_ctrl_pkg::MODE_LOAD_WEIGHT;
            conv_ctrl_pkg::LOAD_INPUT:   return conv_ctrl_pkg::MODE_LOAD_INPUT;
            conv_ctrl_pkg::COMPUTE:      return conv_ctrl_pkg::MODE_SLIDING_WIN;
            conv_ctrl_pkg::DRAIN:        return conv_ctrl_pkg::MODE_UNLOAD;
            default:                     return conv_ctrl_pkg::MODE_IDLE;
        endcase
    endfunction

    task automatic value_error(input string name, input int got, input int expected);
        error_count++;
        $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
    endtask

    task automatic failure(input string msg);
        error_count++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    task automatic check_reset_state();
        if (phase !== conv_ctrl_pkg::IDLE) value_error("phase", int'(phase), 0);
        if (done !== 1'b0) value_error("done", int'(done), 0);
        if (rx_ready !== 1'b0) value_error("rx_ready", int'(rx_ready), 0);
        if (tx_valid !== 1'b0) value_error("tx_valid", int'(tx_valid), 0);
        if (agu !== '0) value_error("agu", int'(agu), 0);
        if (mem !== '0) value_error("mem", int'(mem), 0);
        if (sa !== '0) value_error("sa", int'(sa), 0);
        if (cycle_count !== '0) value_error("cycle_count", int'(cycle_count), 0);
    endtask

    // ======================================================================
    // One falling edge: check outputs, then drive next inputs
    // ======================================================================
    task automatic cycle_step();
        logic exp_write;
        logic exp_tstart;
        logic exp_enable;
        logic exp_astart;
        logic exp_clear;
        logic exp_loadw;
        logic exp_read;
        logic entering;
        exp_write  = (prev_phase == conv_ctrl_pkg::LOAD_WEIGHTS ||
                      prev_phase == conv_ctrl_pkg::LOAD_INPUT) ? prev_rx_valid : 1'b0;
        exp_tstart = (prev_phase == conv_ctrl_pkg::COMPUTE) &&
                     (prev2_phase != conv_ctrl_pkg::COMPUTE);
        exp_enable = (mode_of(prev_phase) != conv_ctrl_pkg::MODE_IDLE);
        exp_astart = exp_enable && (prev_phase != prev2_phase);  // Working phase just began
        exp_clear  = (prev_phase == conv_ctrl_pkg::LOAD_WEIGHTS) &&
                     (prev2_phase != conv_ctrl_pkg::LOAD_WEIGHTS);
        exp_loadw  = (prev_phase == conv_ctrl_pkg::LOAD_WEIGHTS) && prev_rx_valid;
        exp_read   = (prev_phase == conv_ctrl_pkg::COMPUTE) ||
                     (prev_phase == conv_ctrl_pkg::DRAIN);
        entering   = (phase == conv_ctrl_pkg::COMPUTE) && (prev_phase != conv_ctrl_pkg::COMPUTE);

        if (rx_ready && tx_valid) failure("rx_ready and tx_valid high in the same cycle");
        // Registered control groups follow the phase one cycle later
        if (agu.mode !== mode_of(prev_phase))
            value_error("agu.mode", int'(agu.mode), int'(mode_of(prev_phase)));
        if (agu.enable !== exp_enable)
            value_error("agu.enable", int'(agu.enable), int'(exp_enable));
        if (agu.start !== exp_astart)
            value_error("agu.start", int'(agu.start), int'(exp_astart));
        if (sa.enable !== (prev_phase == conv_ctrl_pkg::COMPUTE))
            value_error("sa.enable", int'(sa.enable), int'(prev_phase == conv_ctrl_pkg::COMPUTE));
        if (sa.tile_start !== exp_tstart)
            value_error("sa.tile_start", int'(sa.tile_start), int'(exp_tstart));
        if (sa.clear !== exp_clear)
            value_error("sa.clear", int'(sa.clear), int'(exp_clear));
        if (sa.load_weight !== exp_loadw)
            value_error("sa.load_weight", int'(sa.load_weight), int'(exp_loadw));
        if (mem.write_en !== exp_write)
            value_error("mem.write_en", int'(mem.write_en), int'(exp_write));
        if (mem.read_en !== exp_read)
            value_error("mem.read_en", int'(mem.read_en), int'(exp_read));

        // Span ends on the stream levels
        if (prev_rx_ready && !rx_ready) begin
            if (rx_beats != (first_span ? exp_weights + 64 : 64))
                value_error("rx beats", rx_beats, first_span ? exp_weights + 64 : 64);
            first_span = 1'b0;
            rx_beats   = 0;
        end
        if (prev_tx_valid && !tx_valid) begin
            if (tx_beats != 8) value_error("tx beats", tx_beats, 8);
            drains++;
            tx_beats = 0;
        end
        if (tx_valid && !prev_tx_valid) begin
            if (!tile_done_seen) failure("tx_valid rose before tile_done was driven");
            tile_done_seen = 1'b0;
        end

        // Banking and last tile at each tile start
        if (sa.tile_start) begin
            if (mem.bank_sel !== tiles_started[0])
                value_error("mem.bank_sel", int'(mem.bank_sel), int'(tiles_started[0]));
            if (sa.last_tile !== (tiles_started == exp_tiles - 1))
                value_error("sa.last_tile", int'(sa.last_tile),
                            int'(tiles_started == exp_tiles - 1));
            tiles_started++;
        end

        if (run_active && phase != conv_ctrl_pkg::IDLE) active_cycles++;
        if (done) begin
            if (prev_done) failure("done held longer than one cycle");
            if (!run_active) failure("done pulsed outside a run");
            if (cycle_count !== (conv_ctrl_pkg::CNT_W)'(active_cycles - 1))
                value_error("cycle_count", int'(cycle_count), active_cycles - 1);
            if (drains != exp_tiles) value_error("drain count", drains, exp_tiles);
            if (tiles_started != exp_tiles) value_error("tile starts", tiles_started, exp_tiles);
            done_seen  = 1'b1;
            run_active = 1'b0;
        end

        prev2_phase   = prev_phase;
        prev_phase    = phase;
        prev_rx_ready = rx_ready;
        prev_tx_valid = tx_valid;
        prev_done     = done;

        rx_valid = (rand_range(0, 99) < 70);   // About 70 % valid
        tx_ready = (rand_range(0, 99) < 70);
        if (phase == conv_ctrl_pkg::COMPUTE) begin
            if (entering) begin
                done_delay     = rand_range(1, 6);
                compute_cycles = 0;
            end
            compute_cycles++;
            tile_done = (compute_cycles >= done_delay);
            if (tile_done) tile_done_seen = 1'b1;
        end else begin
            tile_done = 1'b0;
        end

        // Beats land on the coming rising edge
        if (rx_valid && rx_ready) rx_beats++;
        if (tx_valid && tx_ready) tx_beats++;
        prev_rx_valid = rx_valid;              // Sampled together with this phase
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        int                              n_val;
        int                              k_val;
        logic [conv_ctrl_pkg::CNT_W-1:0] held_count;
        lcg_state   = 32'd66421;
        rst_n       = 1'b0;
        start       = 1'b0;
        cfg         = '0;
        rx_valid    = 1'b0;
        tx_ready    = 1'b0;
        tile_done   = 1'b0;
        error_count = 0;
        runs_done   = 0;
        tiles_total = 0;
        exp_tiles   = 0;
        run_active  = 1'b0;
        prev_phase  = conv_ctrl_pkg::IDLE;
        prev2_phase = conv_ctrl_pkg::IDLE;
        prev_rx_valid  = 1'b0;
        prev_rx_ready  = 1'b0;
        prev_tx_valid  = 1'b0;
        prev_done      = 1'b0;
        tile_done_seen = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state();

        for (int run = 0; run < NUM_RUNS; run++) begin
            n_val       = rand_range(16, 20);
            k_val       = rand_range(2, n_val);
            exp_weights = k_val * k_val;
            exp_outputs = (n_val - k_val + 1) * (n_val - k_val + 1);
            exp_tiles   = (exp_outputs + 7) / 8;
            cycle_step();
            start         = 1'b1;
            cfg.n         = (conv_ctrl_pkg::N_W)'(n_val);
            cfg.k         = (conv_ctrl_pkg::K_W)'(k_val);
            rx_beats      = 0;
            tx_beats      = 0;
            drains        = 0;
            tiles_started = 0;
            active_cycles = 0;
            first_span    = 1'b1;
            done_seen     = 1'b0;
            run_active    = 1'b1;
            @(negedge clk);
            cycle_step();
            start = 1'b0;
            while (!done_seen) begin
                @(negedge clk);
                cycle_step();
            end
            held_count = cycle_count;
            // Back to IDLE with the profile count frozen
            repeat (3) begin
                @(negedge clk);
                cycle_step();
                if (phase !== conv_ctrl_pkg::IDLE) value_error("phase", int'(phase), 0);
                if (cycle_count !== held_count)
                    value_error("cycle_count", int'(cycle_count), int'(held_count));
            end
            runs_done++;
            tiles_total += drains;
        end

        $display("Runs: %0d, tiles: %0d, errors: %0d", runs_done, tiles_total, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/conv_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  conv_ctrl_pkg::conv_cfg_t        cfg,
    input  logic                            rx_valid,
    input  logic                            tx_ready,
    input  logic                            tile_done,
    output logic                            done,
    output logic                            rx_ready,
    output logic                            tx_valid,
    output conv_ctrl_pkg::agu_ctrl_t        agu,
    output conv_ctrl_pkg::mem_ctrl_t        mem,
    output conv_ctrl_pkg::sa_ctrl_t         sa,
    output conv_ctrl_pkg::phase_t           phase,
    output logic [conv_ctrl_pkg::CNT_W-1:0] cycle_count
);

    // ======================================================================
    // Internal links
    // ======================================================================
    conv_ctrl_pkg::conv_totals_t totals;           // Latched run sizes
    logic                        in_idle;
    logic                        entry;            // First cycle of a phase
    logic                        first_tile;
    logic                        last_tile_level;

    cfg_latch u_cfg (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .in_idle (in_idle),
        .cfg     (cfg),
        .totals  (totals)
    );

    phase_sequencer u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .rx_valid        (rx_valid),
        .tx_ready        (tx_ready),
        .tile_done       (tile_done),
        .totals          (totals),
        .phase           (phase),
        .entry           (entry),
        .first_tile      (first_tile),
        .last_tile_level (last_tile_level),
        .rx_ready        (rx_ready),
        .tx_valid        (tx_valid),
        .done            (done),
        .cycle_count     (cycle_count),
        .in_idle         (in_idle)
    );

    // Control groups registered from the phase
    ctrl_decoder u_dec (
        .clk             (clk),
        .rst_n           (rst_n),
        .phase           (phase),
        .entry           (entry),
        .first_tile      (first_tile),
        .last_tile_level (last_tile_level),
        .rx_valid        (rx_valid),
        .agu             (agu),
        .mem             (mem),
        .sa              (sa)
    );

endmodule

`default_nettype wire

// ==== logic/ctrl_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  conv_ctrl_pkg::phase_t     phase,
    input  logic                      entry,
    input  logic                      first_tile,
    input  logic                      last_tile_level,
    input  logic                      rx_valid,
    output conv_ctrl_pkg::agu_ctrl_t  agu,
    output conv_ctrl_pkg::mem_ctrl_t  mem,
    output conv_ctrl_pkg::sa_ctrl_t   sa
);

    // ======================================================================
    // Address generator group
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            agu <= '0;
        end else begin
            agu.start <= 1'b0;  // Pulse unless a working phase just began
            case (phase)
                conv_ctrl_pkg::LOAD_WEIGHTS: begin
                    agu.enable <= 1'b1;
                    agu.mode   <= conv_ctrl_pkg::MODE_LOAD_WEIGHT;
                    agu.start  <= entry;
                end
                conv_ctrl_pkg::LOAD_INPUT: begin
                    agu.enable <= 1'b1;
                    agu.mode   <= conv_ctrl_pkg::MODE_LOAD_INPUT;
                    agu.start  <= entry;
                end
                conv_ctrl_pkg::COMPUTE: begin
                    agu.enable <= 1'b1;
                    agu.mode   <= conv_ctrl_pkg::MODE_SLIDING_WIN;  // Window walk over bank
                    agu.start  <= entry;
                end
                conv_ctrl_pkg::DRAIN: begin
                    agu.enable <= 1'b1;
                    agu.mode   <= conv_ctrl_pkg::MODE_UNLOAD;
                    agu.start  <= entry;
                end
                default: begin                                      // IDLE and DONE
                    agu.enable <= 1'b0;
                    agu.mode   <= conv_ctrl_pkg::MODE_IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Memory group
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '0;
        end else begin
            mem.write_en <= 1'b0;
            mem.read_en  <= 1'b0;
            case (phase)
                conv_ctrl_pkg::IDLE: mem.bank_sel <= 1'b0;
                conv_ctrl_pkg::LOAD_WEIGHTS: mem.write_en <= rx_valid;
                conv_ctrl_pkg::LOAD_INPUT: begin
                    mem.write_en <= rx_valid;
                    // Swap banks per tile so compute reads the one just filled
                    if (entry) mem.bank_sel <= first_tile ? 1'b0 : ~mem.bank_sel;
                end
                conv_ctrl_pkg::COMPUTE: mem.read_en <= 1'b1;  // Operands
                conv_ctrl_pkg::DRAIN:   mem.read_en <= 1'b1;  // Results
                default: ;
            endcase
        end
    end

    // ======================================================================
    // Systolic array group
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sa <= '0;
        end else begin
            sa.enable      <= (phase == conv_ctrl_pkg::COMPUTE);
            sa.clear       <= entry && (phase == conv_ctrl_pkg::LOAD_WEIGHTS);
            sa.load_weight <= rx_valid && (phase == conv_ctrl_pkg::LOAD_WEIGHTS);
            sa.tile_start  <= entry && (phase == conv_ctrl_pkg::COMPUTE);
            case (phase)
                conv_ctrl_pkg::COMPUTE:    sa.last_tile <= last_tile_level;
                conv_ctrl_pkg::LOAD_INPUT,
                conv_ctrl_pkg::DRAIN:      ;                 // Keep flag through drain
                default:                   sa.last_tile <= 1'b0;
            endcase
        end
    end

    // Tile start is a pulse, entry must not repeat inside one compute
    assert property (@(posedge clk) disable iff (!rst_n) sa.tile_start |=> !sa.tile_start)
        else $error("ctrl_decoder: tile_start held for two cycles");

endmodule

`default_nettype wire

// ==== logic/phase_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            rx_valid,
    input  logic                            tx_ready,
    input  logic                            tile_done,
    input  conv_ctrl_pkg::conv_totals_t     totals,
    output conv_ctrl_pkg::phase_t           phase,
    output logic                            entry,
    output logic                            first_tile,
    output logic                            last_tile_level,
    output logic                            rx_ready,
    output logic                            tx_valid,
    output logic                            done,
    output logic [conv_ctrl_pkg::CNT_W-1:0] cycle_count,
    output logic                            in_idle
);

    conv_ctrl_pkg::phase_t           phase_nxt;
    logic [conv_ctrl_pkg::CNT_W-1:0] w_cnt;      // Weight beats this run
    logic [conv_ctrl_pkg::CNT_W-1:0] in_cnt;     // Input beats this tile
    logic [conv_ctrl_pkg::CNT_W-1:0] out_cnt;    // Result beats this run
    logic [conv_ctrl_pkg::CNT_W-1:0] out_next;
    logic [conv_ctrl_pkg::CNT_W:0]   out_ahead;  // Drained count after this tile
    logic                            accept;
    logic                            rx_beat;
    logic                            tx_beat;
    logic                            w_last;
    logic                            in_last;
    logic                            drain_last;
    logic                            all_drained;

    // ======================================================================
    // Moore outputs and beat qualifiers
    // ======================================================================
    assign in_idle  = (phase == conv_ctrl_pkg::IDLE);
    assign rx_ready = (phase == conv_ctrl_pkg::LOAD_WEIGHTS) ||
                      (phase == conv_ctrl_pkg::LOAD_INPUT);
    assign tx_valid = (phase == conv_ctrl_pkg::DRAIN);
    assign done     = (phase == conv_ctrl_pkg::DONE);

    assign accept  = start && in_idle;
    assign rx_beat = rx_valid && rx_ready;
    assign tx_beat = tx_valid && tx_ready;

    assign out_next    = out_cnt + 1'b1;
    assign w_last      = rx_beat && (w_cnt == totals.weights - 1'b1);
    assign in_last     = rx_beat &&
        (in_cnt == (conv_ctrl_pkg::CNT_W)'(conv_ctrl_pkg::TILE_INPUTS - 1));
    assign drain_last  = tx_beat &&
        (out_next % (conv_ctrl_pkg::CNT_W)'(conv_ctrl_pkg::TILE_OUTPUTS) == '0);
    assign all_drained = (out_next >= totals.outputs);

    // Final tile when one more drain covers the output total
    assign out_ahead = (conv_ctrl_pkg::CNT_W + 1)'(out_cnt) +
                       (conv_ctrl_pkg::CNT_W + 1)'(conv_ctrl_pkg::TILE_OUTPUTS);
    assign last_tile_level = (out_ahead >= {1'b0, totals.outputs});

    // ======================================================================
    // Next phase
    // ======================================================================
    always_comb begin
        phase_nxt = phase;  // Hold by default
        case (phase)
            conv_ctrl_pkg::IDLE:         if (start)     phase_nxt = conv_ctrl_pkg::LOAD_WEIGHTS;
            conv_ctrl_pkg::LOAD_WEIGHTS: if (w_last)    phase_nxt = conv_ctrl_pkg::LOAD_INPUT;
            conv_ctrl_pkg::LOAD_INPUT:   if (in_last)   phase_nxt = conv_ctrl_pkg::COMPUTE;
            conv_ctrl_pkg::COMPUTE:      if (tile_done) phase_nxt = conv_ctrl_pkg::DRAIN;
            conv_ctrl_pkg::DRAIN: begin
                if (drain_last) begin
                    // More tiles go back for the next input block
                    phase_nxt = all_drained ? conv_ctrl_pkg::DONE : conv_ctrl_pkg::LOAD_INPUT;
                end
            end
            conv_ctrl_pkg::DONE:         phase_nxt = conv_ctrl_pkg::IDLE;  // Single cycle
            default:                     phase_nxt = conv_ctrl_pkg::IDLE;
        endcase
    end

    // Phase register plus entry flag for the first cycle of each phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= conv_ctrl_pkg::IDLE;
            entry <= 1'b0;
        end else begin
            phase <= phase_nxt;
            entry <= (phase_nxt != phase);
        end
    end

    // ======================================================================
    // Beat counters
    // ======================================================================
    // Back-pressure only stalls these, the phase waits on them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_cnt   <= '0;
            in_cnt  <= '0;
            out_cnt <= '0;
        end else if (accept) begin
            w_cnt   <= '0;
            in_cnt  <= '0;
            out_cnt <= '0;
        end else begin
            if (rx_beat && phase == conv_ctrl_pkg::LOAD_WEIGHTS) w_cnt <= w_cnt + 1'b1;
            if (in_last) begin
                in_cnt <= '0;                 // Fresh count for next tile
            end else if (rx_beat && phase == conv_ctrl_pkg::LOAD_INPUT) begin
                in_cnt <= in_cnt + 1'b1;
            end
            if (tx_beat) out_cnt <= out_next;
        end
    end

    // First tile lasts until the first drain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_tile <= 1'b0;
        end else if (accept) begin
            first_tile <= 1'b1;
        end else if (phase == conv_ctrl_pkg::DRAIN) begin
            first_tile <= 1'b0;
        end
    end

    // ======================================================================
    // Profiling counter
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else if (accept) begin
            cycle_count <= '0;
        end else if (!in_idle && !done) begin
            cycle_count <= cycle_count + 1'b1;  // Frozen in DONE and after
        end
    end

    // Weight count stays below the latched total while loading
    assert property (@(posedge clk) disable iff (!rst_n)
        (phase == conv_ctrl_pkg::LOAD_WEIGHTS) |-> (w_cnt < totals.weights))
        else $error("phase_sequencer: weight count passed the weight total");

    // Done only once every result beat has left
    assert property (@(posedge clk) disable iff (!rst_n) done |-> (out_cnt >= totals.outputs))
        else $error("phase_sequencer: done before all results drained");

endmodule

`default_nettype wire

// ==== logic/cfg_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_latch (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       in_idle,
    input  conv_ctrl_pkg::conv_cfg_t    cfg,
    output conv_ctrl_pkg::conv_totals_t totals
);

    // ======================================================================
    // Size arithmetic on the live host fields
    // ======================================================================
    logic [conv_ctrl_pkg::CNT_W-1:0] n_ext;   // N widened to counter width
    logic [conv_ctrl_pkg::CNT_W-1:0] k_ext;   // K widened to counter width
    logic [conv_ctrl_pkg::CNT_W-1:0] side;    // Output edge N-K+1
    logic                            accept;  // Start seen while idle

    assign n_ext  = {{(conv_ctrl_pkg::CNT_W - conv_ctrl_pkg::N_W){1'b0}}, cfg.n};
    assign k_ext  = {{(conv_ctrl_pkg::CNT_W - conv_ctrl_pkg::K_W){1'b0}}, cfg.k};
    assign side   = n_ext - k_ext + 1'b1;
    assign accept = start && in_idle;

    // ======================================================================
    // Totals register
    // ======================================================================
    // Held for the whole run, only reloaded by the next accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            totals <= '0;
        end else if (accept) begin
            totals.weights <= k_ext * k_ext;  // Weight beats to load
            totals.outputs <= side * side;    // Result beats to drain
        end
    end

    // Kernel must fit inside the matrix, else side wraps and the run never ends
    assert property (@(posedge clk) disable iff (!rst_n)
        (start && in_idle) |-> (cfg.k <= cfg.n))
        else $error("cfg_latch: K %0d exceeds N %0d at start", cfg.k, cfg.n);

endmodule

`default_nettype wire

// ==== logic/conv_ctrl_pkg.sv ====
`default_nettype none

package conv_ctrl_pkg;

    // ======================================================================
    // Array geometry and field widths
    // ======================================================================
    localparam int ARRAY_SIZE   = 8;                       // Systolic array edge
    localparam int TILE_INPUTS  = ARRAY_SIZE * ARRAY_SIZE; // Input beats per tile
    localparam int TILE_OUTPUTS = ARRAY_SIZE;              // Result beats per drain
    localparam int N_W          = 7;                       // Matrix size field, 16..64
    localparam int K_W          = 5;                       // Kernel size field, 2..16
    localparam int CNT_W        = 16;                      // Beat and cycle counters

    // ======================================================================
    // Encodings
    // ======================================================================
    // Phase of the sequencer, also exported for debug
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        LOAD_WEIGHTS = 3'd1,
        LOAD_INPUT   = 3'd2,
        COMPUTE      = 3'd3,
        DRAIN        = 3'd4,
        DONE         = 3'd5
    } phase_t;

    // Address generator operating mode
    typedef enum logic [2:0] {
        MODE_IDLE        = 3'd0,
        MODE_LOAD_WEIGHT = 3'd1,
        MODE_LOAD_INPUT  = 3'd2,
        MODE_SLIDING_WIN = 3'd3,
        MODE_UNLOAD      = 3'd4
    } agu_mode_t;

    // ======================================================================
    // Grouped signals
    // ======================================================================
    typedef struct packed {
        logic [N_W-1:0] n;           // Input matrix edge
        logic [K_W-1:0] k;           // Kernel edge
    } conv_cfg_t;

    typedef struct packed {
        logic [CNT_W-1:0] weights;   // K*K
        logic [CNT_W-1:0] outputs;   // (N-K+1)^2
    } conv_totals_t;

    typedef struct packed {
        logic      enable;
        agu_mode_t mode;
        logic      start;            // One cycle on phase entry
    } agu_ctrl_t;

    typedef struct packed {
        logic write_en;
        logic read_en;
        logic bank_sel;              // Ping-pong input bank
    } mem_ctrl_t;

    typedef struct packed {
        logic enable;                // MAC enable
        logic clear;                 // Accumulator clear pulse
        logic load_weight;
        logic tile_start;            // One cycle at compute entry
        logic last_tile;
    } sa_ctrl_t;

endpackage

`default_nettype wire
